/* verif/exu_patterns.txt */
# name op src1 src2 result ovf trap, all hex; op is the alu_op_e code
# ends with mthi/mtlo of zero so a replay starts from clear HI/LO
mfhi  18 00000000 00000000 00000000 0 0
mflo  19 00000000 00000000 00000000 0 0
add   00 00000005 00000007 0000000c 0 0
add   00 7fffffff 00000001 80000000 1 0
addu  01 7fffffff 00000001 80000000 0 0
sub   02 80000000 00000001 7fffffff 1 0
subu  03 00000003 00000005 fffffffe 0 0
slt   04 ffffffff 00000001 00000001 0 0
sltu  05 ffffffff 00000001 00000000 0 0
and   06 f0f0f0f0 ff00ff00 f000f000 0 0
nor   08 f0f0f0f0 0f0f0000 00000f0f 0 0
sll   0a 00000004 00000001 00000010 0 0
sra   0c 00000008 80000000 ff800000 0 0
lui   0d 00000000 00001234 12340000 0 0
clo   0e fff00000 00000000 0000000c 0 0
clz   0f 00000000 00000000 00000020 0 0
movn  10 00000001 aaaa5555 aaaa5555 0 0
movz  11 00000001 aaaa5555 00000000 0 0
teq   12 00000009 00000009 00000000 0 1
tge   14 ffffffff 00000001 00000000 0 0
tltu  17 00000001 ffffffff 00000000 0 1
mult  20 fffffffe 00000003 00000000 0 0
mfhi  18 00000000 00000000 ffffffff 0 0
mflo  19 00000000 00000000 fffffffa 0 0
madd  23 00000002 00000005 00000000 0 0
mflo  19 00000000 00000000 00000004 0 0
multu 21 ffffffff 00000002 00000000 0 0
msubu 26 00000003 00000001 00000000 0 0
mfhi  18 00000000 00000000 00000001 0 0
mflo  19 00000000 00000000 fffffffb 0 0
mul   22 fffffffd 00000007 ffffffeb 0 0
div   28 fffffff9 00000002 00000000 0 0
mfhi  18 00000000 00000000 ffffffff 0 0
mflo  19 00000000 00000000 fffffffd 0 0
divu  29 00000064 00000000 00000000 0 0
mfhi  18 00000000 00000000 00000064 0 0
mflo  19 00000000 00000000 ffffffff 0 0
mthi  1a 00000000 00000000 00000000 0 0
mtlo  1b 00000000 00000000 00000000 0 0

/* vlog.f */
hw/alu_pkg.sv
hw/exu_link_pkg.sv
hw/exu_req_queue.sv
hw/alu_core.sv
hw/muldiv_unit.sv
hw/exu_retire.sv
hw/exu_top.sv
verif/exu_tb.sv

/* run_sim.sh */
#!/bin/sh
# build the exu testbench with Verilator, run it and look for the pass line
verilator --binary --timing --top-module exu_tb -f vlog.f -o exu_sim || exit 1
out=$(./obj_dir/exu_sim)
echo "$out"
echo "$out" | grep -qx "Test OK" && echo "simulation passed" || { echo "simulation failed"; exit 1; }

/* verif/exu_tb.sv */
`timescale 1ns/10ps
`default_nettype none

module exu_tb;
    import alu_pkg::*;
    import exu_link_pkg::*;

    localparam int SEND_LIMIT  = 2000;  // cycles without an upstream credit
    localparam int DRAIN_LIMIT = 4000;

    typedef struct packed {
        logic [5:0] op;
        word_t      src1;
        word_t      src2;
        word_t      result;
        logic       ovf;
        logic       trap;
    } pattern_t;

    logic     clk = 1'b0;
    logic     reset;
    exu_req_t req;
    logic     req_valid;
    logic     req_credit;
    exu_rsp_t rsp;
    logic     rsp_valid;
    logic     rsp_credit = 1'b0;

    pattern_t pats[$];
    string    pat_names[$];
    int       n_pats;
    int       up_sent;      // requests issued upstream
    int       up_returned;  // req_credit pulses seen
    int       dn_used;      // responses seen
    int       dn_granted;   // rsp_credit pulses returned
    int       received;
    int       pass_cnt;
    int       fail_cnt;
    int       mon_errors;
    int       flow_errors;
    logic     timed_out;
    int       cycle;
    int       scheduled;
    int       due_q[$];     // cycles at which a credit goes back

    always #20 clk = ~clk;

    exu_top u_dut (
        .clk        (clk),
        .reset      (reset),
        .req        (req),
        .req_valid  (req_valid),
        .req_credit (req_credit),
        .rsp        (rsp),
        .rsp_valid  (rsp_valid),
        .rsp_credit (rsp_credit)
    );

    task automatic compare(input string name, input logic [31:0] got,
                           input logic [31:0] exp, output int bad);
        bad = 0;
        if (got !== exp) begin
            $display("ERROR %s got %h expected %h", name, got, exp);
            bad = 1;
        end
    endtask

    function automatic exu_req_t make_req(input int k);
        exu_req_t r;
        r.op   = alu_op_e'(pats[k % n_pats].op);
        r.src1 = pats[k % n_pats].src1;
        r.src2 = pats[k % n_pats].src2;
        r.tag  = tag_t'(k);  // wraps every 16 requests
        return r;
    endfunction

    // downstream model returns at most one credit per cycle
    always @(posedge clk) begin
        int delay;
        int slot;
        if (reset) begin
            rsp_credit <= 1'b0;
        end else begin
            cycle++;
            while (scheduled < dn_used) begin
                // second replay withholds credits for a long stretch
                delay = (scheduled >= n_pats) ? 15 + int'($urandom % 40) : int'($urandom % 6);
                due_q.push_back(cycle + delay);
                scheduled++;
            end
            slot = -1;
            foreach (due_q[k]) begin
                if (slot < 0 && due_q[k] <= cycle) begin
                    slot = k;
                end
            end
            if (slot >= 0) begin
                due_q.delete(slot);
            end
            rsp_credit <= (slot >= 0);
        end
    end

    always @(negedge clk) begin
        pattern_t p;
        int       bad;
        int       miss;
        int       idx;
        if (!reset) begin
            if (req_credit) begin
                if (up_returned >= up_sent) begin
                    $display("upstream credit returned with no request queued");
                    mon_errors++;
                end
                up_returned++;
            end
            if (rsp_valid) begin
                if (dn_used >= int'(RSP_CREDITS) + dn_granted) begin
                    $display("response sent without a downstream credit");
                    mon_errors++;
                end
                dn_used++;
                if (received >= up_sent) begin
                    $display("response with no request outstanding");
                    mon_errors++;
                end else begin
                    idx  = received % n_pats;
                    p    = pats[idx];
                    miss = 0;
                    compare("rsp.result", rsp.result, p.result, bad);
                    miss += bad;
                    compare("rsp.tag", 32'(rsp.tag), 32'(tag_t'(received)), bad);
                    miss += bad;
                    compare("rsp.ovf", 32'(rsp.ovf), 32'(p.ovf), bad);
                    miss += bad;
                    compare("rsp.trap", 32'(rsp.trap), 32'(p.trap), bad);
                    miss += bad;
                    if (miss == 0) begin
                        pass_cnt++;
                    end else begin
                        fail_cnt++;
                    end
                    $display("round %0d line %0d %s result %h %s", received / n_pats + 1,
                             idx + 1, pat_names[idx], rsp.result, (miss == 0) ? "ok" : "mismatch");
                    received++;
                end
            end
            if (rsp_credit) begin
                dn_granted++;  // DUT counts it at the next edge
            end
        end
    end

    initial begin
        int         fd;
        int         total;
        int         waited;
        int         bad;
        string      line;
        string      name;
        logic [5:0] op;
        word_t      s1;
        word_t      s2;
        word_t      res;
        logic       ovf;
        logic       trap;
        pattern_t   p;
        timed_out   = 1'b0;
        flow_errors = 0;
        reset     <= 1'b1;
        req       <= '0;
        req_valid <= 1'b0;
        void'($urandom(32'h42cccb25));
        fd = $fopen("verif/exu_patterns.txt", "r");
        if (fd == 0) begin
            $display("cannot open verif/exu_patterns.txt");
            flow_errors++;
        end else begin
            while (!$feof(fd)) begin
                line = "";
                void'($fgets(line, fd));
                if (line.len() > 0 && line.getc(0) != "#") begin
                    if ($sscanf(line, "%s %h %h %h %h %h %h", name, op, s1, s2, res, ovf,
                                trap) == 7) begin
                        p.op     = op;
                        p.src1   = s1;
                        p.src2   = s2;
                        p.result = res;
                        p.ovf    = ovf;
                        p.trap   = trap;
                        pats.push_back(p);
                        pat_names.push_back(name);
                    end
                end
            end
            $fclose(fd);
        end
        n_pats = pats.size();
        total  = 2 * n_pats;  // file replayed twice

        repeat (8) @(posedge clk);
        reset <= 1'b0;
        @(negedge clk);
        compare("req_credit", 32'(req_credit), 32'h0, bad);
        flow_errors += bad;
        compare("rsp_valid", 32'(rsp_valid), 32'h0, bad);
        flow_errors += bad;

        waited = 0;
        while (up_sent < total && !timed_out) begin
            @(posedge clk);
            if (REQ_DEPTH - up_sent + up_returned > 0) begin
                req       <= make_req(up_sent);
                req_valid <= 1'b1;
                up_sent++;
                waited = 0;
            end else begin
                req_valid <= 1'b0;
                waited++;
                if (waited > SEND_LIMIT) begin
                    $display("no response within limit, upstream credit never returned");
                    timed_out = 1'b1;
                end
            end
        end
        @(posedge clk);
        req_valid <= 1'b0;

        waited = 0;
        while (received < total && !timed_out) begin
            @(posedge clk);
            waited++;
            if (waited > DRAIN_LIMIT) begin
                $display("no response within limit, %0d of %0d received", received, total);
                timed_out = 1'b1;
            end
        end
        waited = 0;
        while (up_returned != up_sent && !timed_out) begin
            @(posedge clk);
            waited++;
            if (waited > SEND_LIMIT) begin
                $display("no response within limit, upstream credits still missing");
                timed_out = 1'b1;
            end
        end
        repeat (20) @(posedge clk);  // window for stray responses
        compare("upstream credits", 32'(REQ_DEPTH - up_sent + up_returned), 32'(REQ_DEPTH), bad);
        flow_errors += bad;

        $display("tests %0d passed %0d failed %0d", total, pass_cnt, fail_cnt);
        if (!timed_out && flow_errors == 0 && mon_errors == 0 && pass_cnt == total) begin
            $display("Test OK");
        end else begin
            $display("Test FAILED");
        end
        $finish;
    end

endmodule

`default_nettype wire

/* hw/exu_top.sv */
`timescale 1ns/10ps
`default_nettype none

module exu_top (
    input  logic                   clk,
    input  logic                   reset,
    input  exu_link_pkg::exu_req_t req,
    input  logic                   req_valid,
    output logic                   req_credit,
    output exu_link_pkg::exu_rsp_t rsp,
    output logic                   rsp_valid,
    input  logic                   rsp_credit
);
    import alu_pkg::*;
    import exu_link_pkg::*;

    exu_req_t head;
    logic     head_valid;
    logic     take;
    logic     core_load;
    exu_rsp_t core_rsp;
    exu_rsp_t md_rsp;
    logic     md_busy;
    logic     md_done;
    word_t    hi;
    word_t    lo;
    logic     retire_ready;

    assign take      = head_valid & retire_ready & ~md_busy;  // one op in flight
    assign core_load = take & ~is_long_op(head.op);

    exu_req_queue u_queue (
        .clk        (clk),
        .reset      (reset),
        .req        (req),
        .req_valid  (req_valid),
        .head       (head),
        .head_valid (head_valid),
        .take       (take),
        .req_credit (req_credit)
    );

    alu_core u_core (
        .head (head),
        .rsp  (core_rsp),
        .hi   (hi),
        .lo   (lo)
    );

    muldiv_unit u_muldiv (
        .clk    (clk),
        .reset  (reset),
        .head   (head),
        .take   (take),
        .busy   (md_busy),
        .done   (md_done),
        .result (md_rsp),
        .hi     (hi),
        .lo     (lo)
    );

    exu_retire u_retire (
        .clk          (clk),
        .reset        (reset),
        .core_rsp     (core_rsp),
        .core_load    (core_load),
        .md_rsp       (md_rsp),
        .md_done      (md_done),
        .retire_ready (retire_ready),
        .rsp          (rsp),
        .rsp_valid    (rsp_valid),
        .rsp_credit   (rsp_credit)
    );

endmodule

`default_nettype wire

/* hw/exu_retire.sv */
`timescale 1ns/10ps
`default_nettype none

module exu_retire (
    input  logic                   clk,
    input  logic                   reset,
    input  exu_link_pkg::exu_rsp_t core_rsp,
    input  logic                   core_load,
    input  exu_link_pkg::exu_rsp_t md_rsp,
    input  logic                   md_done,
    output logic                   retire_ready,
    output exu_link_pkg::exu_rsp_t rsp,
    output logic                   rsp_valid,
    input  logic                   rsp_credit
);
    import exu_link_pkg::*;

    exu_rsp_t    hold;
    logic        full;
    credit_cnt_t credits;
    logic        send;

    assign send         = full & (credits != '0);
    assign rsp_valid    = send;
    assign rsp          = hold;
    assign retire_ready = ~full | send;  // slot frees as it leaves

    always_ff @(posedge clk) begin
        if (reset) begin
            full    <= 1'b0;
            credits <= RSP_CREDITS;
        end else begin
            full    <= core_load | md_done | (full & ~send);
            credits <= credits - credit_cnt_t'(send) + credit_cnt_t'(rsp_credit);
        end
    end

    // never both in one cycle, long ops block take
    always_ff @(posedge clk) begin
        if (core_load) begin
            hold <= core_rsp;
        end else if (md_done) begin
            hold <= md_rsp;
        end
    end

endmodule

`default_nettype wire

/* hw/muldiv_unit.sv */
`timescale 1ns/10ps
`default_nettype none

module muldiv_unit (
    input  logic                   clk,
    input  logic                   reset,
    input  exu_link_pkg::exu_req_t head,
    input  logic                   take,
    output logic                   busy,
    output logic                   done,
    output exu_link_pkg::exu_rsp_t result,
    output alu_pkg::word_t         hi,
    output alu_pkg::word_t         lo
);
    import alu_pkg::*;
    import exu_link_pkg::*;

    typedef enum logic [1:0] {
        ST_IDLE,
        ST_MUL,
        ST_DIV,
        ST_FINISH
    } md_state_e;

    md_state_e   state;
    logic [5:0]  step;
    alu_op_e     op;
    tag_t        tag;
    logic        neg_q;     // product or quotient negative
    logic        neg_r;     // remainder takes dividend sign
    logic        div_zero;
    dword_t      acc;       // product, or {rem, quo} while dividing
    dword_t      mcand;
    word_t       mplier;    // divisor magnitude for div
    logic        head_signed;
    logic        head_div;
    word_t       a_mag;
    word_t       b_mag;
    logic        start;
    logic [32:0] trial;
    dword_t      prod;
    word_t       quo;
    word_t       rem;
    dword_t      hilo_next;

    function automatic dword_t partial(input dword_t mc, input word_t mp);
        return mc * dword_t'(mp[MUL_CHUNK-1:0]);
    endfunction

    assign head_signed = head.op inside {OP_MULT, OP_MUL, OP_MADD, OP_MSUB, OP_DIV};
    assign head_div    = head.op inside {OP_DIV, OP_DIVU};
    assign a_mag = (head_signed & head.src1[31]) ? -head.src1 : head.src1;
    assign b_mag = (head_signed & head.src2[31]) ? -head.src2 : head.src2;

    assign busy  = (state != ST_IDLE);
    assign done  = (state == ST_FINISH);
    assign start = take & ~busy & is_long_op(head.op);

    assign trial = acc[63:31] - {1'b0, mplier};  // shifted remainder minus divisor

    assign prod = neg_q ? -acc : acc;
    assign quo  = div_zero ? '1 : (neg_q ? -acc[31:0] : acc[31:0]);
    assign rem  = neg_r ? -acc[63:32] : acc[63:32];

    always_comb begin
        case (op)
            OP_MULT, OP_MULTU: hilo_next = prod;
            OP_MADD, OP_MADDU: hilo_next = {hi, lo} + prod;
            OP_MSUB, OP_MSUBU: hilo_next = {hi, lo} - prod;
            OP_DIV, OP_DIVU:   hilo_next = {rem, quo};
            default:           hilo_next = {hi, lo};  // mul keeps HI/LO
        endcase
        result.result = (op == OP_MUL) ? prod[31:0] : '0;
        result.tag    = tag;
        result.ovf    = 1'b0;
        result.trap   = 1'b0;
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            state <= ST_IDLE;
            step  <= '0;
        end else begin
            case (state)
                ST_IDLE: begin
                    if (start) begin
                        state <= head_div ? ST_DIV : ST_MUL;
                        step  <= head_div ? 6'd0 : 6'd1;  // first chunk done on take
                    end
                end
                ST_MUL: begin
                    step <= step + 1'b1;
                    if (step == 6'(MUL_CYCLES - 1)) begin
                        state <= ST_FINISH;
                    end
                end
                ST_DIV: begin
                    step <= step + 1'b1;
                    if (step == 6'(DIV_STEPS - 1)) begin
                        state <= ST_FINISH;
                    end
                end
                default: state <= ST_IDLE;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (start) begin
            op       <= head.op;
            tag      <= head.tag;
            neg_q    <= head_signed & (head.src1[31] ^ head.src2[31]);
            neg_r    <= head_signed & head.src1[31];
            div_zero <= (head.src2 == '0);
            mcand    <= dword_t'(a_mag) << MUL_CHUNK;
            mplier   <= head_div ? b_mag : b_mag >> MUL_CHUNK;
            acc      <= head_div ? dword_t'(a_mag) : partial(dword_t'(a_mag), b_mag);
        end else if (state == ST_MUL) begin
            acc    <= acc + partial(mcand, mplier);
            mcand  <= mcand << MUL_CHUNK;
            mplier <= mplier >> MUL_CHUNK;
        end else if (state == ST_DIV) begin
            // restoring step, keep shifted remainder on borrow
            acc <= trial[32] ? {acc[62:0], 1'b0} : {trial[31:0], acc[30:0], 1'b1};
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            hi <= '0;
            lo <= '0;
        end else if (state == ST_FINISH) begin
            {hi, lo} <= hilo_next;
        end else if (take & (head.op == OP_MTHI)) begin
            hi <= head.src1;
        end else if (take & (head.op == OP_MTLO)) begin
            lo <= head.src1;
        end
    end

endmodule

`default_nettype wire

/* hw/alu_core.sv */
`timescale 1ns/10ps
`default_nettype none

module alu_core (
    input  exu_link_pkg::exu_req_t head,
    output exu_link_pkg::exu_rsp_t rsp,
    input  alu_pkg::word_t         hi,
    input  alu_pkg::word_t         lo
);
    import alu_pkg::*;

    word_t  a;
    word_t  b;
    shamt_t sa;
    logic   sub_mode;
    word_t  adder_b;
    word_t  sum;
    logic   carry;
    logic   lt_s;
    logic   lt_u;
    logic   ovf;
    word_t  result;
    logic   trap;

    function automatic word_t lead_zeros(input word_t x);
        word_t n;
        logic  hit;
        n   = '0;
        hit = 1'b0;
        for (int i = 31; i >= 0; i--) begin
            hit = hit | x[i];
            if (!hit) begin
                n = n + 1'b1;
            end
        end
        return n;  // 32 when x is all zero
    endfunction

    assign a  = head.src1;
    assign b  = head.src2;
    assign sa = a[4:0];  // shift amount from src1, value from src2

    // one adder for add/sub, compares and compare traps
    assign sub_mode = head.op inside {OP_SUB, OP_SUBU, OP_SLT, OP_SLTU,
                                      OP_TGE, OP_TGEU, OP_TLT, OP_TLTU};
    assign adder_b  = sub_mode ? ~b : b;
    assign {carry, sum} = {1'b0, a} + {1'b0, adder_b} + {32'b0, sub_mode};

    assign lt_s = (a[31] & ~b[31]) | (~(a[31] ^ b[31]) & sum[31]);
    assign lt_u = ~carry;  // borrow out

    // same-sign operands, result of the other sign
    assign ovf = (head.op inside {OP_ADD, OP_SUB}) & (a[31] == adder_b[31]) & (sum[31] != a[31]);

    always_comb begin
        result = '0;
        trap   = 1'b0;
        case (head.op)
            OP_ADD, OP_ADDU, OP_SUB, OP_SUBU: result = sum;
            OP_SLT:  result = {31'b0, lt_s};
            OP_SLTU: result = {31'b0, lt_u};
            OP_AND:  result = a & b;
            OP_OR:   result = a | b;
            OP_NOR:  result = ~(a | b);
            OP_XOR:  result = a ^ b;
            OP_SLL:  result = b << sa;
            OP_SRL:  result = b >> sa;
            OP_SRA:  result = $signed(b) >>> sa;
            OP_LUI:  result = {b[15:0], 16'b0};
            OP_CLO:  result = lead_zeros(~a);
            OP_CLZ:  result = lead_zeros(a);
            OP_MOVN: result = (a != '0) ? b : '0;
            OP_MOVZ: result = (a == '0) ? b : '0;
            OP_MFHI: result = hi;
            OP_MFLO: result = lo;
            OP_TEQ:  trap = (a == b);
            OP_TNE:  trap = (a != b);
            OP_TGE:  trap = ~lt_s;
            OP_TGEU: trap = ~lt_u;
            OP_TLT:  trap = lt_s;
            OP_TLTU: trap = lt_u;
            default: result = '0;  // mthi/mtlo and long ops
        endcase
        rsp.result = result;
        rsp.tag    = head.tag;
        rsp.ovf    = ovf;
        rsp.trap   = trap;
    end

endmodule

`default_nettype wire

/* hw/exu_req_queue.sv */
`timescale 1ns/10ps
`default_nettype none

module exu_req_queue (
    input  logic                   clk,
    input  logic                   reset,
    input  exu_link_pkg::exu_req_t req,
    input  logic                   req_valid,
    output exu_link_pkg::exu_req_t head,
    output logic                   head_valid,
    input  logic                   take,
    output logic                   req_credit
);
    import exu_link_pkg::*;

    exu_req_t               mem [REQ_DEPTH];
    logic [REQ_PTR_W-1:0]   rd_ptr;
    logic [REQ_PTR_W-1:0]   wr_ptr;
    credit_cnt_t            count;
    logic                   push;
    logic                   pop;

    assign head_valid = (count != '0);
    assign head       = mem[rd_ptr];
    assign pop        = take & head_valid;
    assign push       = req_valid & (count != credit_cnt_t'(REQ_DEPTH));  // full never seen
    assign req_credit = pop;  // slot freed, give it back

    always_ff @(posedge clk) begin
        if (reset) begin
            rd_ptr <= '0;
            wr_ptr <= '0;
            count  <= '0;
        end else begin
            if (push) begin
                wr_ptr <= wr_ptr + 1'b1;  // depth is a power of two
            end
            if (pop) begin
                rd_ptr <= rd_ptr + 1'b1;
            end
            count <= count + credit_cnt_t'(push) - credit_cnt_t'(pop);
        end
    end

    always_ff @(posedge clk) begin
        if (push) begin
            mem[wr_ptr] <= req;
        end
    end

endmodule

`default_nettype wire

/* hw/exu_link_pkg.sv */
`default_nettype none

package exu_link_pkg;

    typedef logic [3:0] tag_t;
    typedef logic [2:0] credit_cnt_t;

    localparam int          REQ_DEPTH   = 4;  // upstream starts with this many credits
    localparam int          REQ_PTR_W   = $clog2(REQ_DEPTH);
    localparam credit_cnt_t RSP_CREDITS = 3'd2;

    typedef struct packed {
        alu_pkg::alu_op_e op;
        alu_pkg::word_t   src1;
        alu_pkg::word_t   src2;
        tag_t             tag;
    } exu_req_t;

    typedef struct packed {
        alu_pkg::word_t result;
        tag_t           tag;   // echoed from the request
        logic           ovf;
        logic           trap;
    } exu_rsp_t;

endpackage

`default_nettype wire

/* hw/alu_pkg.sv */
`default_nettype none

package alu_pkg;

    typedef logic [31:0] word_t;
    typedef logic [63:0] dword_t;   // HI:LO
    typedef logic [4:0]  shamt_t;

    localparam int MUL_CYCLES = 3;
    localparam int MUL_CHUNK  = (32 + MUL_CYCLES - 1) / MUL_CYCLES;  // multiplier bits per pass
    localparam int DIV_STEPS  = 32;

    // single-cycle ops below 32, HI/LO-owning long ops from 32 up
    typedef enum logic [5:0] {
        OP_ADD   = 6'd0,   // checked
        OP_ADDU  = 6'd1,
        OP_SUB   = 6'd2,   // checked
        OP_SUBU  = 6'd3,
        OP_SLT   = 6'd4,
        OP_SLTU  = 6'd5,
        OP_AND   = 6'd6,
        OP_OR    = 6'd7,
        OP_NOR   = 6'd8,
        OP_XOR   = 6'd9,
        OP_SLL   = 6'd10,
        OP_SRL   = 6'd11,
        OP_SRA   = 6'd12,
        OP_LUI   = 6'd13,
        OP_CLO   = 6'd14,
        OP_CLZ   = 6'd15,
        OP_MOVN  = 6'd16,
        OP_MOVZ  = 6'd17,
        OP_TEQ   = 6'd18,
        OP_TNE   = 6'd19,
        OP_TGE   = 6'd20,
        OP_TGEU  = 6'd21,
        OP_TLT   = 6'd22,
        OP_TLTU  = 6'd23,
        OP_MFHI  = 6'd24,
        OP_MFLO  = 6'd25,
        OP_MTHI  = 6'd26,
        OP_MTLO  = 6'd27,
        OP_MULT  = 6'd32,
        OP_MULTU = 6'd33,
        OP_MUL   = 6'd34,
        OP_MADD  = 6'd35,
        OP_MADDU = 6'd36,
        OP_MSUB  = 6'd37,
        OP_MSUBU = 6'd38,
        OP_DIV   = 6'd40,
        OP_DIVU  = 6'd41
    } alu_op_e;

    function automatic logic is_long_op(input alu_op_e op);
        return op[5];  // multi-cycle group
    endfunction

endpackage

`default_nettype wire
